// ==== flist.f ====
+incdir+sim
logic/keccak_pkg.sv
logic/keccak_round.sv
logic/keccak_padder.sv
logic/keccak_permutation.sv
logic/keccak_core.sv
sim/keccak_tb.sv

// ==== logic/keccak_core.sv ====
// ==============================
// keccak_core, top level
// byte lane reordering between padder
// and permutation, digest and its valid flag
// ==============================
`timescale 1ns/100ps
`default_nettype none

module keccak_core (
    input  logic                clk,
    input  logic                reset,
    input  keccak_pkg::word_t   in_data,
    input  logic                in_valid,
    input  logic                in_last,
    input  logic [1:0]          in_bytes,
    output logic                in_ready,
    output keccak_pkg::digest_t digest,       // digest byte 0 in bits 511:504
    output logic                digest_valid  // sticky until reset
);

    keccak_pkg::block_t pad_blk;    // message byte order from the padder
    keccak_pkg::block_t perm_blk;   // keccak lane order into the permutation
    keccak_pkg::state_t perm_state;
    logic               blk_valid;
    logic               blk_ready;
    logic               blk_last;
    logic               done_last;

    // reverses the bytes of one lane, which maps message order to keccak order
    // and back again since the mapping is its own inverse
    function automatic keccak_pkg::lane_t swap_bytes(input keccak_pkg::lane_t v);
        keccak_pkg::lane_t r;
        for (int k = 0; k < 8; k++)
            r[8*k +: 8] = v[56 - 8*k +: 8];
        return r;
    endfunction

    // ==============================
    // byte lane reordering
    // ==============================
    genvar w;
    generate
        for (w = 0; w < 9; w++)
        begin : g_blk_lane
            assign perm_blk[575 - 64*w -: 64] = swap_bytes(pad_blk[575 - 64*w -: 64]);
        end
        // the digest is lanes 0 to 7, the top 512 state bits
        for (w = 0; w < 8; w++)
        begin : g_dig_lane
            assign digest[511 - 64*w -: 64] = swap_bytes(perm_state[1599 - 64*w -: 64]);
        end
    endgenerate

    keccak_padder u_keccak_padder (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_bytes  (in_bytes),
        .in_ready  (in_ready),
        .blk_data  (pad_blk),
        .blk_valid (blk_valid),
        .blk_last  (blk_last),
        .blk_ready (blk_ready)
    );

    keccak_permutation u_keccak_permutation (
        .clk       (clk),
        .reset     (reset),
        .blk_data  (perm_blk),
        .blk_valid (blk_valid),
        .blk_last  (blk_last),
        .blk_ready (blk_ready),
        .state     (perm_state),
        .done_last (done_last)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            digest_valid <= 1'b0;
        else if (done_last)
            digest_valid <= 1'b1;  // set once per message, cleared only by reset
    end

    // nothing reaches the permutation after the final block, so the digest holds
    a_digest_sticky: assert property (@(posedge clk) disable iff (reset)
        digest_valid |=> digest_valid && $stable(digest))
        else $error("digest changed or lost its valid flag without reset");

endmodule

`default_nettype wire

// ==== logic/keccak_padder.sv ====
// ==============================
// keccak_padder
// packs 32 bit words into 576 bit rate blocks
// and appends the 0x01 ... 0x80 padding
// ==============================
`timescale 1ns/100ps
`default_nettype none

module keccak_padder (
    input  logic               clk,
    input  logic               reset,
    input  keccak_pkg::word_t  in_data,
    input  logic               in_valid,
    input  logic               in_last,
    input  logic [1:0]         in_bytes,  // valid bytes of the last word counted from the top
    output logic               in_ready,
    output keccak_pkg::block_t blk_data,  // message byte order with byte 0 in bits 575:568
    output logic               blk_valid,
    output logic               blk_last,
    input  logic               blk_ready
);

    logic [4:0]         slot;          // next word slot in the block from 0 to 17
    logic               msg_done;      // last word taken, no more input until reset
    logic               last_pending;  // the final padded block has not been handed off yet
    logic               accept;        // input word transfer
    logic               xfer;          // block transfer to the permutation
    keccak_pkg::word_t  keep_mask;     // message bytes kept from the last word
    keccak_pkg::word_t  marker;        // position of the 0x01 pad byte in the last word
    keccak_pkg::block_t blk_next;

    // a held block stalls the input, and after the last word nothing more is taken
    assign in_ready = !blk_valid && !msg_done;
    assign accept   = in_valid && in_ready;
    assign xfer     = blk_valid && blk_ready;
    assign blk_last = last_pending;

    // the last word carries at most 3 bytes, so the 0x01 byte always fits in it
    // a message ending on a word boundary sends a zero byte last word, which
    // is what gives a padding only block when the previous block was full
    always_comb
    begin
        case (in_bytes)
            2'd0:
            begin
                keep_mask = 32'h0000_0000;
                marker    = 32'h0100_0000;
            end
            2'd1:
            begin
                keep_mask = 32'hff00_0000;
                marker    = 32'h0001_0000;
            end
            2'd2:
            begin
                keep_mask = 32'hffff_0000;
                marker    = 32'h0000_0100;
            end
            default:
            begin
                keep_mask = 32'hffff_ff00;
                marker    = 32'h0000_0001;
            end
        endcase
    end

    // ==============================
    // next block contents
    // ==============================
    always_comb
    begin
        blk_next = blk_data;
        for (int k = 0; k < keccak_pkg::RATE_WORDS; k++)
        begin
            if (k == slot)
                blk_next[575 - 32*k -: 32] = in_last ? ((in_data & keep_mask) | marker)
                                                     : in_data;
            else if (in_last && k > slot)
                blk_next[575 - 32*k -: 32] = '0;  // stale words from the previous block
        end
        // the final byte of the block becomes 0x81 when the 0x01 landed there too
        if (in_last)
            blk_next[7:0] = blk_next[7:0] | 8'h80;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            blk_data <= blk_next;  // only written while no block is offered
    end

    // ==============================
    // slot counter and handshake flags
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot         <= '0;
            blk_valid    <= 1'b0;
            msg_done     <= 1'b0;
            last_pending <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                if (in_last)
                begin
                    blk_valid    <= 1'b1;  // padding is complete in this same cycle
                    msg_done     <= 1'b1;
                    last_pending <= 1'b1;
                    slot         <= '0;
                end
                else if (slot == keccak_pkg::RATE_WORDS - 1)
                begin
                    blk_valid <= 1'b1;  // slot 17 filled so the block is full
                    slot      <= '0;
                end
                else
                    slot <= slot + 5'd1;
            end
            if (xfer)
            begin
                blk_valid    <= 1'b0;
                last_pending <= 1'b0;
            end
        end
    end

    // a full or final block is offered on the next cycle with the input stalled
    a_block_offered: assert property (@(posedge clk) disable iff (reset)
        accept && (in_last || slot == keccak_pkg::RATE_WORDS - 1) |=> blk_valid && !in_ready)
        else $error("padder did not offer a block after it filled one");

    // an offered block stays put until the permutation takes it
    a_block_held: assert property (@(posedge clk) disable iff (reset)
        blk_valid && !blk_ready |=> blk_valid && $stable(blk_data) && $stable(blk_last))
        else $error("padder changed a block that was not yet taken");

endmodule

`default_nettype wire

// ==== logic/keccak_permutation.sv ====
// ==============================
// keccak_permutation
// state register, absorb step and round
// counter that iterates keccak_round
// ==============================
`timescale 1ns/100ps
`default_nettype none

module keccak_permutation (
    input  logic               clk,
    input  logic               reset,
    input  keccak_pkg::block_t blk_data,   // keccak lane order with lane 0 in the top bits
    input  logic               blk_valid,
    input  logic               blk_last,
    output logic               blk_ready,
    output keccak_pkg::state_t state,
    output logic               done_last   // one cycle pulse after the final block
);

    keccak_pkg::perm_state_e fsm;
    logic [4:0]              round_cnt;  // index of the round applied on the next edge
    logic                    last_tag;   // block in flight was the final one
    keccak_pkg::state_t      absorbed;
    keccak_pkg::state_t      round_out;

    assign blk_ready = (fsm == keccak_pkg::idle);

    // the rate covers lanes 0 to 8, which sit in the top 576 bits
    assign absorbed = state ^ {blk_data, 1024'b0};

    keccak_round u_keccak_round (
        .state_in  (state),
        .round_idx (round_cnt),
        .state_out (round_out)
    );

    // ==============================
    // control FSM and state register
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fsm       <= keccak_pkg::idle;
            round_cnt <= '0;
            last_tag  <= 1'b0;
            done_last <= 1'b0;
            state     <= '0;  // keccak starts from the all zero state
        end
        else
        begin
            done_last <= 1'b0;
            case (fsm)
                keccak_pkg::idle:
                begin
                    if (blk_valid)
                    begin
                        state     <= absorbed;  // xor in on the transfer edge
                        last_tag  <= blk_last;
                        round_cnt <= '0;
                        fsm       <= keccak_pkg::absorb;
                    end
                end
                keccak_pkg::absorb:
                begin
                    state     <= round_out;  // round 0 on the freshly absorbed state
                    round_cnt <= 5'd1;
                    fsm       <= keccak_pkg::run;
                end
                keccak_pkg::run:
                begin
                    state <= round_out;
                    if (round_cnt == keccak_pkg::NUM_ROUNDS - 1)
                    begin
                        round_cnt <= '0;
                        done_last <= last_tag;  // only the final block reports
                        fsm       <= keccak_pkg::idle;
                    end
                    else
                        round_cnt <= round_cnt + 5'd1;
                end
                default: fsm <= keccak_pkg::idle;
            endcase
        end
    end

    // the FSM is idle again exactly 25 cycles after the block transfer that started it
    a_idle_after_rounds: assert property (@(posedge clk) disable iff (reset)
        blk_ready && !$past(blk_ready) |-> $past(blk_valid && blk_ready, 25))
        else $error("permutation did not return to idle 25 cycles after a block transfer");

    a_round_range: assert property (@(posedge clk) disable iff (reset)
        round_cnt < keccak_pkg::NUM_ROUNDS)
        else $error("round counter ran past the last round");

endmodule

`default_nettype wire

// ==== logic/keccak_pkg.sv ====
// ==============================
// shared keccak-512 definitions
// width typedefs, size constants, FSM encoding
// and the iota round-constant lookup
// ==============================
`default_nettype none

package keccak_pkg;

    // ==============================
    // widths
    // ==============================
    typedef logic [31:0]   word_t;   // input word, first message byte in bits 31:24
    typedef logic [63:0]   lane_t;   // one keccak lane
    typedef logic [575:0]  block_t;  // rate block of 9 lanes, lane 0 in the top bits
    typedef logic [1599:0] state_t;  // full state of 25 lanes, lane 0 in the top bits
    typedef logic [511:0]  digest_t; // hash output in message byte order

    localparam int RATE_WORDS = 18; // 576 bit rate over 32 bit words
    localparam int NUM_ROUNDS = 24; // rounds of keccak-f[1600]

    // permutation controller states, idle is the only state that takes a block
    typedef enum logic [1:0] {
        idle,
        absorb,
        run
    } perm_state_e;

    // iota constant for round idx, anything past 23 reads as zero
    function automatic lane_t round_const(input logic [4:0] idx);
        case (idx)
            5'd0:    return 64'h0000_0000_0000_0001;
            5'd1:    return 64'h0000_0000_0000_8082;
            5'd2:    return 64'h8000_0000_0000_808a;
            5'd3:    return 64'h8000_0000_8000_8000;
            5'd4:    return 64'h0000_0000_0000_808b;
            5'd5:    return 64'h0000_0000_8000_0001;
            5'd6:    return 64'h8000_0000_8000_8081;
            5'd7:    return 64'h8000_0000_0000_8009;
            5'd8:    return 64'h0000_0000_0000_008a;
            5'd9:    return 64'h0000_0000_0000_0088;
            5'd10:   return 64'h0000_0000_8000_8009;
            5'd11:   return 64'h0000_0000_8000_000a;
            5'd12:   return 64'h0000_0000_8000_808b;
            5'd13:   return 64'h8000_0000_0000_008b;
            5'd14:   return 64'h8000_0000_0000_8089;
            5'd15:   return 64'h8000_0000_0000_8003;
            5'd16:   return 64'h8000_0000_0000_8002;
            5'd17:   return 64'h8000_0000_0000_0080;
            5'd18:   return 64'h0000_0000_0000_800a;
            5'd19:   return 64'h8000_0000_8000_000a;
            5'd20:   return 64'h8000_0000_8000_8081;
            5'd21:   return 64'h8000_0000_0000_8080;
            5'd22:   return 64'h0000_0000_8000_0001;
            5'd23:   return 64'h8000_0000_8000_8008;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/keccak_round.sv ====
// ==============================
// keccak_round
// one keccak-f[1600] round as pure logic
// theta, rho, pi, chi and iota
// ==============================
`timescale 1ns/100ps
`default_nettype none

module keccak_round (
    input  keccak_pkg::state_t state_in,   // lane x + 5y in bits 1599-64(x+5y) downwards
    input  logic [4:0]         round_idx,  // selects the iota constant
    output keccak_pkg::state_t state_out
);

    // rho rotation per lane, indexed by x + 5y
    localparam int RHO_OFFSET [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    keccak_pkg::lane_t a [25];  // input lanes
    keccak_pkg::lane_t c [5];   // column parities
    keccak_pkg::lane_t d [5];   // theta correction per column
    keccak_pkg::lane_t b [25];  // after theta, rho and pi
    keccak_pkg::lane_t e [25];  // after chi

    // left rotation by a constant, a shift by 64 gives zero so n = 0 is a plain copy
    function automatic keccak_pkg::lane_t rotl(input keccak_pkg::lane_t v, input int n);
        return (v << n) | (v >> (64 - n));
    endfunction

    genvar x, i;

    // ==============================
    // theta column parities
    // ==============================
    generate
        for (x = 0; x < 5; x++)
        begin : g_col
            assign c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];
            // left neighbour parity with the rotated right neighbour parity
            assign d[x] = c[(x + 4) % 5] ^ rotl(c[(x + 1) % 5], 1);
        end
    endgenerate

    // ==============================
    // per lane steps
    // ==============================
    generate
        for (i = 0; i < 25; i++)
        begin : g_lane
            localparam int X      = i % 5;
            localparam int Y      = i / 5;
            // pi moves lane (x, y) to (y, 2x + 3y)
            localparam int PI_DST = Y + 5 * ((2*X + 3*Y) % 5);

            assign a[i] = state_in[1599 - 64*i -: 64];

            // theta, then rho, written straight into the pi position
            assign b[PI_DST] = rotl(a[i] ^ d[X], RHO_OFFSET[i]);

            // chi works along each row
            assign e[i] = b[i] ^ (~b[(X + 1) % 5 + 5*Y] & b[(X + 2) % 5 + 5*Y]);

            if (i == 0)
            begin : g_iota
                // iota only touches lane (0, 0)
                assign state_out[1599 -: 64] = e[0] ^ keccak_pkg::round_const(round_idx);
            end
            else
            begin : g_pass
                assign state_out[1599 - 64*i -: 64] = e[i];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== sim/keccak_ref.svh ====
// ==============================
// behavioural keccak-512 reference
// lane rotation, keccak-f[1600] and the
// padded sponge over a message byte array
// ==============================
`ifndef KECCAK_REF_SVH
`define KECCAK_REF_SVH

// left rotation of one 64 bit lane
function automatic logic [63:0] rotate_lane(input logic [63:0] v, input int n);
    if (n == 0)
        return v;
    return (v << n) | (v >> (64 - n));
endfunction

// the full 24 round permutation
// lane x + 5y sits at bits 64(x + 5y) upwards, so block byte j lines up with bits 8j upwards
function automatic logic [1599:0] keccak_f(input logic [1599:0] s);
    logic [63:0]   a [25];
    logic [63:0]   b [25];
    logic [63:0]   c [5];
    logic [63:0]   d [5];
    logic [63:0]   rc;
    logic [7:0]    lfsr;
    logic [1599:0] res;
    int            rho [25];
    int            x;
    int            y;
    int            t;
    int            i;
    int            j;
    int            r;
    for (i = 0; i < 25; i++)
        a[i] = s[64*i +: 64];
    // rho offsets follow the (x, y) orbit that starts at (1, 0)
    rho[0] = 0;
    x = 1;
    y = 0;
    for (t = 0; t < 24; t++)
    begin
        rho[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
        j = x;
        x = y;
        y = (2*j + 3*y) % 5;  // (x, y) moves to (y, 2x + 3y)
    end
    lfsr = 8'h01;  // rc(0) opens the round constant sequence
    for (r = 0; r < 24; r++)
    begin
        // theta
        for (x = 0; x < 5; x++)
            c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];
        for (x = 0; x < 5; x++)
            d[x] = c[(x + 4) % 5] ^ rotate_lane(c[(x + 1) % 5], 1);
        // rho and pi in one pass
        for (i = 0; i < 25; i++)
        begin
            x = i % 5;
            y = i / 5;
            b[y + 5*((2*x + 3*y) % 5)] = rotate_lane(a[i] ^ d[x], rho[i]);
        end
        // chi along each row
        for (i = 0; i < 25; i++)
        begin
            x = i % 5;
            y = i / 5;
            a[i] = b[i] ^ (~b[(x + 1) % 5 + 5*y] & b[(x + 2) % 5 + 5*y]);
        end
        // iota takes seven lfsr outputs, placed at bit 2^j - 1
        rc = '0;
        for (j = 0; j < 7; j++)
        begin
            rc[(1 << j) - 1] = lfsr[0];
            lfsr = {lfsr[6:0], 1'b0} ^ (lfsr[7] ? 8'h71 : 8'h00);  // x^8 + x^6 + x^5 + x^4 + 1
        end
        a[0] = a[0] ^ rc;
    end
    for (i = 0; i < 25; i++)
        res[64*i +: 64] = a[i];
    return res;
endfunction

// keccak-512 of the first len bytes, rate 72 bytes, digest byte 0 in bits 511:504
function automatic logic [511:0] keccak_ref(input logic [7:0] message [256], input int len);
    logic [7:0]    padded [288];
    logic [1599:0] s;
    logic [511:0]  dig;
    int            nblk;
    int            blk;
    int            m;
    nblk = len / 72 + 1;  // at least one pad byte, so a full last block gets a spare one
    for (m = 0; m < 288; m++)
        padded[m] = (m < len) ? message[m] : 8'h00;
    padded[len] = padded[len] | 8'h01;
    padded[72*nblk - 1] = padded[72*nblk - 1] | 8'h80;  // gives 0x81 when both meet
    s = '0;
    for (blk = 0; blk < nblk; blk++)
    begin
        for (m = 0; m < 72; m++)
            s[8*m +: 8] = s[8*m +: 8] ^ padded[72*blk + m];
        s = keccak_f(s);
    end
    for (m = 0; m < 64; m++)
        dig[511 - 8*m -: 8] = s[8*m +: 8];
    return dig;
endfunction

`endif

// ==== sim/keccak_tb.sv ====
// ==============================
// keccak_core testbench
// clock, reset, word stimulus with gaps,
// digest compare against the reference
// ==============================
`timescale 1ns/100ps
`default_nettype none

module keccak_tb;

    logic                clk;
    logic                reset;
    keccak_pkg::word_t   in_data;
    logic                in_valid;
    logic                in_last;
    logic [1:0]          in_bytes;
    logic                in_ready;
    keccak_pkg::digest_t digest;
    logic                digest_valid;

    integer     seed;           // shared by message bytes and valid gaps
    logic [7:0] msg [256];      // current message whose bytes past its length are filler

    `include "keccak_ref.svh"

    keccak_core u_keccak_core (
        .clk          (clk),
        .reset        (reset),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_bytes     (in_bytes),
        .in_ready     (in_ready),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    always #5 clk = ~clk;  // 10 ns period

    // ==============================
    // error reporting
    // ==============================
    task automatic stop_failed;
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR at %0d ns: %s", $time, reason);
        stop_failed();
    endtask

    task automatic check_value(input string name, input logic [511:0] actual,
                               input logic [511:0] expected);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            stop_failed();
        end
    endtask

    // ==============================
    // reset and stimulus
    // ==============================
    // two cycles of reset, then the reset values are sampled on the next edge
    task automatic apply_reset;
        reset    <= 1'b1;
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_bytes <= 2'd0;
        in_data  <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("in_ready", in_ready, 1);
        check_value("digest_valid", digest_valid, 0);
        check_value("digest", digest, 0);  // state register cleared to zero
    endtask

    // streams len bytes plus the closing word, which carries len % 4 bytes
    task automatic send_message(input int len, input bit gaps);
        int nwords;
        int w;
        int waited;
        bit presenting;
        bit expect_stall;
        nwords       = len / 4 + 1;
        w            = 0;
        waited       = 0;
        presenting   = 1'b0;
        expect_stall = 1'b0;
        while (w < nwords)
        begin
            if (!presenting)
            begin
                if (!gaps || ($random(seed) & 3) != 0)
                begin
                    in_data  <= {msg[4*w], msg[4*w + 1], msg[4*w + 2], msg[4*w + 3]};
                    in_last  <= (w == nwords - 1);
                    in_bytes <= (w == nwords - 1) ? len[1:0] : 2'd0;
                    in_valid <= 1'b1;
                    presenting = 1'b1;
                end
                else
                    in_valid <= 1'b0;  // random gap
            end
            @(posedge clk);
            check_value("digest_valid", digest_valid, 0);  // no digest before the last word
            if (expect_stall)
            begin
                check_value("in_ready", in_ready, 0);  // full block held for the permutation
                expect_stall = 1'b0;
            end
            if (presenting && in_ready)
            begin
                expect_stall = (w % 18 == 17);  // this word filled slot 17
                w++;
                presenting = 1'b0;
                waited     = 0;
            end
            else
            begin
                waited++;
                if (waited > 200)
                    abort_run("input word was not accepted within 200 cycles");
            end
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_bytes <= 2'd0;
    endtask

    // ==============================
    // compare process
    // ==============================
    task automatic compare_digest(input logic [511:0] expected);
        int waited;
        waited = 0;
        while (digest_valid !== 1'b1)
        begin
            @(posedge clk);
            waited++;
            if (waited > 2000)
                abort_run("digest_valid did not rise within 2000 cycles");
        end
        check_value("digest", digest, expected);
        // inputs are idle now, the result must not move
        repeat (50)
        begin
            @(posedge clk);
            check_value("digest_valid", digest_valid, 1);
            check_value("digest", digest, expected);
        end
    endtask

    task automatic run_message(input int len, input bit gaps);
        logic [511:0] expected;
        int           k;
        for (k = 0; k < 256; k++)
            msg[k] = $random(seed);
        expected = keccak_ref(msg, len);
        apply_reset();
        fork
            send_message(len, gaps);
            compare_digest(expected);
        join
    endtask

    initial
    begin
        seed     = 32'h72234167;
        clk      = 1'b0;
        reset    = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_bytes = 2'd0;
        @(posedge clk);
        // every in_bytes value, including an empty closing word
        run_message(0, 1'b0);
        run_message(1, 1'b0);
        run_message(2, 1'b0);
        run_message(3, 1'b0);
        run_message(4, 1'b0);
        // 0x81 marker, extra padding block, two blocks
        run_message(71, 1'b0);
        run_message(72, 1'b0);
        run_message(143, 1'b1);
        // three blocks with back-pressure and gaps
        run_message(200, 1'b1);
        apply_reset();  // digest and its valid flag clear again
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
